//--- src/cmat_defines.svh
// matrix size, element count, memory geometry and adder latency macros
`ifndef CMAT_DEFINES_SVH
`define CMAT_DEFINES_SVH

// rows and columns of every matrix
`define CMAT_N 2

// elements per matrix
`define CMAT_ELEMS (`CMAT_N * `CMAT_N)

// complex words in the shared memory
`define MEM_DEPTH 64

// address width of the shared memory
`define MEM_AW 6

// cycles from in_stb to out_stb of fp64_add
`define FP_ADD_LAT 3

`endif

//--- src/cmat_pkg.sv
// complex element, memory request, op enum and command types
`include "cmat_defines.svh"

package cmat_pkg;

    // IEEE double real and imaginary halves
    typedef struct packed {
        logic [63:0] re;
        logic [63:0] im;
    } cplx_t;

    // one access to the shared memory
    typedef struct packed {
        logic               we;
        logic [`MEM_AW-1:0] addr;
        cplx_t              wdata;
    } mem_req_t;

    // encoding also indexes the busy vector of the top level
    typedef enum logic {
        OP_ADD    = 1'b0,
        OP_CONJ_T = 1'b1
    } cmat_op_e;

    // base addresses of the operand and result matrices
    typedef struct packed {
        cmat_op_e           op;
        logic [`MEM_AW-1:0] src_a;
        logic [`MEM_AW-1:0] src_b;
        logic [`MEM_AW-1:0] dst;
    } cmat_cmd_t;

endpackage

//--- src/fp64_add.sv
// three-stage IEEE double adder with denormal flush and round to nearest even
module fp64_add (
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] a,
    input  logic [63:0] b,
    input  logic        in_stb,
    output logic [63:0] z,
    output logic        out_stb
);

    // leading zeros of a 56-bit mantissa
    function automatic logic [5:0] lzc56(input logic [55:0] v);
        logic [5:0] n;
        n = 6'd56;
        for (int k = 0; k < 56; k++) begin
            if (v[k]) begin
                n = 6'(55 - k);
            end
        end
        return n;
    endfunction

    logic [10:0]        ea;
    logic [10:0]        eb;
    logic [10:0]        e_l;
    logic [10:0]        e_s;
    logic [10:0]        e_diff;
    logic [52:0]        ma;
    logic [52:0]        mb;
    logic [52:0]        m_l;
    logic [52:0]        m_s;
    logic               a_big;
    logic [5:0]         sh;
    logic [111:0]       wide;

    logic               s1_valid;
    logic               s1_sign;
    logic               s1_sub;
    logic [10:0]        s1_exp;
    logic [55:0]        s1_ml;
    logic [55:0]        s1_ms;

    logic               s2_valid;
    logic               s2_sign;
    logic               s2_sub;
    logic [10:0]        s2_exp;
    logic [56:0]        s2_sum;

    logic [5:0]         lz;
    logic [55:0]        norm;
    logic signed [12:0] e_n;
    logic signed [12:0] e_r;
    logic               rnd;
    logic [53:0]        mant;
    logic [51:0]        frac;
    logic [63:0]        z_n;

    // stage 1: unpack, order by magnitude, align the smaller operand
    always_comb begin
        ea = a[62:52];
        eb = b[62:52];
        // denormals count as zero
        ma = (ea == 11'd0) ? 53'd0 : {1'b1, a[51:0]};
        mb = (eb == 11'd0) ? 53'd0 : {1'b1, b[51:0]};
        a_big = {ea, ma} >= {eb, mb};
        e_l = a_big ? ea : eb;
        e_s = a_big ? eb : ea;
        m_l = a_big ? ma : mb;
        m_s = a_big ? mb : ma;
        e_diff = e_l - e_s;
        sh = (e_diff > 11'd60) ? 6'd60 : e_diff[5:0];
        // three guard bits on top, shifted-out bits land below
        wide = {m_s, 3'b000, 56'd0} >> sh;
    end

    // stage 3: normalize, round and pack
    always_comb begin
        lz = lzc56(s2_sum[55:0]);
        if (s2_sum[56]) begin
            norm = {s2_sum[56:2], s2_sum[1] | s2_sum[0]};
            e_n = $signed({2'b00, s2_exp}) + 13'sd1;
        end else begin
            norm = s2_sum[55:0] << lz;
            e_n = $signed({2'b00, s2_exp}) - $signed({7'd0, lz});
        end
        // guard, round, sticky sit in norm[2:0]
        rnd = norm[2] & (norm[3] | norm[1] | norm[0]);
        mant = {1'b0, norm[55:3]} + 54'(rnd);
        if (mant[53]) begin
            frac = mant[52:1];
            e_r = e_n + 13'sd1;
        end else begin
            frac = mant[51:0];
            e_r = e_n;
        end
        if (s2_sum == 57'd0) begin
            // exact cancellation gives +0, equal-sign zeros keep their sign
            z_n = {s2_sign & ~s2_sub, 63'd0};
        end else if (e_r < 13'sd1) begin
            z_n = 64'd0;
        end else begin
            z_n = {s2_sign, e_r[10:0], frac};
        end
    end

    always_ff @(posedge clk) begin
        s1_sign <= a_big ? a[63] : b[63];
        s1_sub  <= a[63] ^ b[63];
        s1_exp  <= e_l;
        s1_ml   <= {m_l, 3'b000};
        s1_ms   <= {wide[111:57], wide[56] | (|wide[55:0])};

        // stage 2: magnitude add or subtract, larger operand first
        s2_sign <= s1_sign;
        s2_sub  <= s1_sub;
        s2_exp  <= s1_exp;
        if (s1_sub) begin
            s2_sum <= {1'b0, s1_ml} - {1'b0, s1_ms};
        end else begin
            s2_sum <= {1'b0, s1_ml} + {1'b0, s1_ms};
        end

        z <= z_n;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            out_stb  <= 1'b0;
        end else begin
            s1_valid <= in_stb;
            s2_valid <= s1_valid;
            out_stb  <= s2_valid;
        end
    end

endmodule

//--- src/mem_arbiter.sv
// fixed-priority three-way memory arbiter with read data steering
module mem_arbiter #(
    parameter type req_t = logic [7:0]
) (
    input  logic       clk,
    input  logic       rst,
    input  req_t       req_in [3],
    input  logic [2:0] valid_in,
    output logic [2:0] gnt,
    output req_t       req_out,
    output logic       valid_out,
    input  logic       rvalid,
    output logic [2:0] rvalid_out
);

    logic [2:0] gnt_q;

    // requester 0 wins, then 1, then 2
    always_comb begin
        gnt     = 3'b000;
        req_out = req_in[0];
        if (valid_in[0]) begin
            gnt = 3'b001;
        end else if (valid_in[1]) begin
            gnt     = 3'b010;
            req_out = req_in[1];
        end else if (valid_in[2]) begin
            gnt     = 3'b100;
            req_out = req_in[2];
        end
    end

    assign valid_out = |valid_in;

    // last cycle's winner owns any read data now returning
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_q <= 3'b000;
        end else begin
            gnt_q <= gnt;
        end
    end

    assign rvalid_out = gnt_q & {3{rvalid}};

    assert property (@(posedge clk) disable iff (rst) $onehot0(gnt));

    // memory only answers a request granted the cycle before
    assert property (@(posedge clk) disable iff (rst) rvalid |-> $past(valid_out));

endmodule

//--- src/cmat_mem.sv
// single-port complex element memory with registered read data
`include "cmat_defines.svh"

module cmat_mem
    import cmat_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t req,
    input  logic     req_valid,
    output cplx_t    rdata,
    output logic     rvalid
);

    cplx_t mem [`MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (req_valid && req.we) begin
            mem[req.addr] <= req.wdata;
        end
        if (req_valid && !req.we) begin
            rdata <= mem[req.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= req_valid && !req.we;
        end
    end

endmodule

//--- src/cmat_add_engine.sv
// element-wise complex matrix add engine with a memory request FSM
`include "cmat_defines.svh"

module cmat_add_engine
    import cmat_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_stb,
    input  cmat_cmd_t cmd,
    output mem_req_t  mem_req,
    output logic      mem_valid,
    input  logic      mem_gnt,
    input  logic      rvalid,
    input  cplx_t     rdata,
    output logic      busy,
    output logic      done
);

    localparam int IW = $clog2(`CMAT_ELEMS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_A,
        S_RD_B,
        S_WAIT_B,
        S_ISSUE,
        S_WAIT_SUM,
        S_WR
    } state_e;

    state_e        state;
    logic [IW-1:0] idx;
    cmat_cmd_t     cmd_q;
    cplx_t         a_q;
    cplx_t         b_q;
    cplx_t         sum_q;
    logic          start;
    logic          last;
    logic          add_stb;
    logic          re_stb;
    logic          im_stb;
    logic [63:0]   re_z;
    logic [63:0]   im_z;

    assign start   = cmd_stb && (cmd.op == OP_ADD);
    assign last    = (idx == IW'(`CMAT_ELEMS - 1));
    assign add_stb = (state == S_ISSUE);
    assign busy    = (state != S_IDLE);

    fp64_add u_add_re (
        .clk(clk), .rst(rst), .a(a_q.re), .b(b_q.re), .in_stb(add_stb),
        .z(re_z), .out_stb(re_stb)
    );

    fp64_add u_add_im (
        .clk(clk), .rst(rst), .a(a_q.im), .b(b_q.im), .in_stb(add_stb),
        .z(im_z), .out_stb(im_stb)
    );

    // request stays put until granted since it depends only on state and idx
    always_comb begin
        mem_valid     = (state == S_RD_A) || (state == S_RD_B) || (state == S_WR);
        mem_req.we    = (state == S_WR);
        mem_req.wdata = sum_q;
        case (state)
            S_RD_B:  mem_req.addr = cmd_q.src_b + `MEM_AW'(idx);
            S_WR:    mem_req.addr = cmd_q.dst + `MEM_AW'(idx);
            default: mem_req.addr = cmd_q.src_a + `MEM_AW'(idx);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    cmd_q <= cmd;
                    idx   <= '0;
                    state <= S_RD_A;
                end
                S_RD_A: if (mem_gnt) state <= S_RD_B;
                S_RD_B: begin
                    // A returns while B is still being requested
                    if (rvalid) a_q <= rdata;
                    if (mem_gnt) state <= S_WAIT_B;
                end
                S_WAIT_B: if (rvalid) begin
                    b_q   <= rdata;
                    state <= S_ISSUE;
                end
                S_ISSUE: state <= S_WAIT_SUM;
                S_WAIT_SUM: if (re_stb) begin
                    sum_q <= '{re: re_z, im: im_z};
                    state <= S_WR;
                end
                S_WR: if (mem_gnt) begin
                    if (last) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= S_RD_A;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

    // both halves come back together, FP_ADD_LAT cycles after launch
    assert property (@(posedge clk) disable iff (rst)
        add_stb |-> ##`FP_ADD_LAT (re_stb && im_stb));

endmodule

//--- src/cmat_conj_transpose.sv
// conjugate-transpose engine copying a source matrix into a destination region
`include "cmat_defines.svh"

module cmat_conj_transpose
    import cmat_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_stb,
    input  cmat_cmd_t cmd,
    output mem_req_t  mem_req,
    output logic      mem_valid,
    input  logic      mem_gnt,
    input  logic      rvalid,
    input  cplx_t     rdata,
    output logic      busy,
    output logic      done
);

    localparam int JW = $clog2(`CMAT_N + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_WAIT,
        S_WR
    } state_e;

    state_e        state;
    logic [JW-1:0] row;
    logic [JW-1:0] col;
    cmat_cmd_t     cmd_q;
    cplx_t         data_q;
    logic          start;
    logic          last_col;

    assign start    = cmd_stb && (cmd.op == OP_CONJ_T);
    assign last_col = (col == JW'(`CMAT_N - 1));
    assign busy     = (state != S_IDLE);

    // read at row*N+col, write at col*N+row
    always_comb begin
        mem_valid     = (state == S_RD) || (state == S_WR);
        mem_req.we    = (state == S_WR);
        mem_req.wdata = data_q;
        if (state == S_WR) begin
            mem_req.addr = cmd_q.dst + `MEM_AW'(col * `CMAT_N + row);
        end else begin
            mem_req.addr = cmd_q.src_a + `MEM_AW'(row * `CMAT_N + col);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            row   <= '0;
            col   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    cmd_q <= cmd;
                    row   <= '0;
                    col   <= '0;
                    state <= S_RD;
                end
                S_RD: if (mem_gnt) state <= S_WAIT;
                S_WAIT: if (rvalid) begin
                    // conjugate by flipping the imaginary sign bit
                    data_q <= '{re: rdata.re, im: {~rdata.im[63], rdata.im[62:0]}};
                    state  <= S_WR;
                end
                S_WR: if (mem_gnt) begin
                    state <= S_RD;
                    if (last_col) begin
                        col <= '0;
                        row <= row + 1'b1;
                        if (row == JW'(`CMAT_N - 1)) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

    // a stalled request must wait unchanged for the arbiter
    assert property (@(posedge clk) disable iff (rst)
        (mem_valid && !mem_gnt) |=> (mem_valid && $stable(mem_req)));

endmodule

//--- src/cmat_unit.sv
// complex matrix unit top with host port, engines, arbiter, memory and done merge
module cmat_unit
    import cmat_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_stb,
    input  cmat_cmd_t cmd,
    input  logic      host_stb,
    input  mem_req_t  host_req,
    output cplx_t     host_rdata,
    output logic      host_rvalid,
    output logic [1:0] busy,
    output logic      done,
    output cmat_op_e  done_op
);

    mem_req_t   add_req;
    mem_req_t   ct_req;
    mem_req_t   arb_req [3];
    mem_req_t   mem_req;
    logic       add_valid;
    logic       ct_valid;
    logic       mem_valid;
    logic       mem_rvalid;
    logic [2:0] arb_gnt;
    logic [2:0] arb_rvalid;
    cplx_t      mem_rdata;
    logic       add_done;
    logic       ct_done;
    logic       ct_pend;

    // requester order sets priority: host, add, conjugate transpose
    assign arb_req[0] = host_req;
    assign arb_req[1] = add_req;
    assign arb_req[2] = ct_req;

    assign host_rdata  = mem_rdata;
    assign host_rvalid = arb_rvalid[0];

    cmat_add_engine u_add (
        .clk(clk), .rst(rst), .cmd_stb(cmd_stb), .cmd(cmd),
        .mem_req(add_req), .mem_valid(add_valid), .mem_gnt(arb_gnt[1]),
        .rvalid(arb_rvalid[1]), .rdata(mem_rdata),
        .busy(busy[OP_ADD]), .done(add_done)
    );

    cmat_conj_transpose u_ct (
        .clk(clk), .rst(rst), .cmd_stb(cmd_stb), .cmd(cmd),
        .mem_req(ct_req), .mem_valid(ct_valid), .mem_gnt(arb_gnt[2]),
        .rvalid(arb_rvalid[2]), .rdata(mem_rdata),
        .busy(busy[OP_CONJ_T]), .done(ct_done)
    );

    mem_arbiter #(
        .req_t(mem_req_t)
    ) u_arb (
        .clk(clk), .rst(rst), .req_in(arb_req),
        .valid_in({ct_valid, add_valid, host_stb}), .gnt(arb_gnt),
        .req_out(mem_req), .valid_out(mem_valid),
        .rvalid(mem_rvalid), .rvalid_out(arb_rvalid)
    );

    cmat_mem u_mem (
        .clk(clk), .rst(rst), .req(mem_req), .req_valid(mem_valid),
        .rdata(mem_rdata), .rvalid(mem_rvalid)
    );

    // on a tie the add report goes first, the other waits one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ct_pend <= 1'b0;
        end else begin
            ct_pend <= add_done && ct_done;
        end
    end

    assign done    = add_done || ct_done || ct_pend;
    assign done_op = add_done ? OP_ADD : OP_CONJ_T;

endmodule

//--- testbench/tb_cmat_unit.sv
// testbench for cmat_unit with stimulus, reference model, assertions, watchdog and report
`include "cmat_defines.svh"

module tb_cmat_unit
    import cmat_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = `CMAT_N;
    localparam int ELEMS = `CMAT_ELEMS;
    // four engine operations, each bounded by 40 cycles per element
    localparam int NUM_OPS = 4;
    localparam int OP_BOUND = 40 * ELEMS;
    localparam int WATCHDOG_CYCLES = NUM_OPS * OP_BOUND + 1500;

    logic       clk;
    logic       rst;
    logic       cmd_stb;
    cmat_cmd_t  cmd;
    logic       host_stb;
    mem_req_t   host_req;
    cplx_t      host_rdata;
    logic       host_rvalid;
    logic [1:0] busy;
    logic       done;
    cmat_op_e   done_op;

    integer seed;
    int     errors;
    int     checks;
    int     done_cnt [2];
    logic   started;
    // expected contents of the shared memory
    cplx_t  model [`MEM_DEPTH];

    cmat_unit dut (
        .clk(clk), .rst(rst), .cmd_stb(cmd_stb), .cmd(cmd),
        .host_stb(host_stb), .host_req(host_req), .host_rdata(host_rdata),
        .host_rvalid(host_rvalid), .busy(busy), .done(done), .done_op(done_op)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            done_cnt[0] <= 0;
            done_cnt[1] <= 0;
        end else if (done) begin
            done_cnt[done_op] <= done_cnt[done_op] + 1;
        end
    end

    task automatic note_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0d ns: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic rand_double(output logic [63:0] d);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        // exponents 1003 to 1034 keep every sum normal
        d = {r2[31], 11'd1003 + {6'd0, r2[4:0]}, r0[19:0], r1};
    endtask

    task automatic rand_elem(output cplx_t e);
        logic [63:0] re;
        logic [63:0] im;
        rand_double(re);
        rand_double(im);
        e = '{re: re, im: im};
    endtask

    function automatic cplx_t sum_ref(input cplx_t x, input cplx_t y);
        cplx_t s;
        s.re = $realtobits($bitstoreal(x.re) + $bitstoreal(y.re));
        s.im = $realtobits($bitstoreal(x.im) + $bitstoreal(y.im));
        return s;
    endfunction

    function automatic cplx_t conj_ref(input cplx_t x);
        cplx_t c;
        c.re = x.re;
        c.im = $realtobits(-$bitstoreal(x.im));
        return c;
    endfunction

    task automatic host_write(input int addr, input cplx_t data);
        host_req.we    = 1'b1;
        host_req.addr  = `MEM_AW'(addr);
        host_req.wdata = data;
        host_stb       = 1'b1;
        model[addr]    = data;
        next_cycle();
        host_stb = 1'b0;
    endtask

    // the read latency is fixed at one cycle
    task automatic host_read_check(input int addr);
        host_req.we   = 1'b0;
        host_req.addr = `MEM_AW'(addr);
        host_stb      = 1'b1;
        next_cycle();
        host_stb = 1'b0;
        checks++;
        if (!host_rvalid) begin
            note_failure($sformatf("no read data returned for address %0d", addr));
        end else begin
            assert (host_rdata == model[addr]) else
                note_mismatch($sformatf("addr %0d got %h %h expected %h %h", addr,
                    host_rdata.re, host_rdata.im, model[addr].re, model[addr].im));
        end
    endtask

    task automatic load_add_operands(input int a_base, input int b_base);
        cplx_t a;
        cplx_t b;
        for (int k = 0; k < ELEMS; k++) begin
            rand_elem(a);
            rand_elem(b);
            if (k == 0) begin
                // equal magnitude of opposite sign cancels to +0
                b.re = {~a.re[63], a.re[62:0]};
                b.im = {~a.im[63], a.im[62:0]};
            end else if (k == 1) begin
                // wide exponent gap on an add and on a subtract
                b.re = {a.re[63], a.re[62:52] - 11'd45, b.re[51:0]};
                b.im = {~a.im[63], a.im[62:52] - 11'd57, b.im[51:0]};
            end
            host_write(a_base + k, a);
            host_write(b_base + k, b);
        end
    endtask

    task automatic load_random(input int base);
        cplx_t e;
        for (int k = 0; k < ELEMS; k++) begin
            rand_elem(e);
            host_write(base + k, e);
        end
    endtask

    task automatic predict_add(input int a_base, input int b_base, input int d_base);
        for (int k = 0; k < ELEMS; k++) begin
            model[d_base + k] = sum_ref(model[a_base + k], model[b_base + k]);
        end
    endtask

    task automatic predict_conj(input int s_base, input int d_base);
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                model[d_base + j * N + i] = conj_ref(model[s_base + i * N + j]);
            end
        end
    endtask

    task automatic issue_cmd(input cmat_op_e op, input int a, input int b, input int d);
        cmd.op    = op;
        cmd.src_a = `MEM_AW'(a);
        cmd.src_b = `MEM_AW'(b);
        cmd.dst   = `MEM_AW'(d);
        cmd_stb   = 1'b1;
        next_cycle();
        cmd_stb = 1'b0;
    endtask

    task automatic wait_done(input cmat_op_e op, input int target);
        int cycles;
        cycles = 0;
        while (done_cnt[op] < target && cycles < OP_BOUND) begin
            next_cycle();
            cycles++;
        end
        if (done_cnt[op] < target) begin
            note_failure($sformatf("%s engine never signalled done", op.name()));
        end
    endtask

    task automatic check_done_count(input int add_n, input int ct_n);
        repeat (3) next_cycle();
        checks++;
        assert (done_cnt[OP_ADD] == add_n && done_cnt[OP_CONJ_T] == ct_n) else
            note_failure($sformatf("saw %0d add and %0d conj done pulses, wanted %0d and %0d",
                done_cnt[OP_ADD], done_cnt[OP_CONJ_T], add_n, ct_n));
    endtask

    task automatic check_region(input int base);
        for (int k = 0; k < ELEMS; k++) begin
            host_read_check(base + k);
        end
    endtask

    // quiet outputs between reset release and the first stimulus
    assert property (@(posedge clk) disable iff (rst)
        !started |-> (!done && busy == 2'b00 && !host_rvalid))
        else note_failure("done, busy or host_rvalid active before any stimulus");

    assert property (@(posedge clk) disable iff (rst)
        (host_stb && !host_req.we) |=> host_rvalid)
        else note_failure("host read data missing one cycle after the read strobe");

    assert property (@(posedge clk) disable iff (rst)
        host_rvalid |-> $past(host_stb && !host_req.we))
        else note_failure("host_rvalid raised without a read strobe one cycle earlier");

    assert property (@(posedge clk) disable iff (rst)
        (cmd_stb && cmd.op == OP_ADD) |=> busy[OP_ADD])
        else note_failure("add engine not busy after its command");

    assert property (@(posedge clk) disable iff (rst)
        (cmd_stb && cmd.op == OP_CONJ_T) |=> busy[OP_CONJ_T])
        else note_failure("conjugate-transpose engine not busy after its command");

    assert property (@(posedge clk) disable iff (rst)
        $fell(busy[OP_ADD]) |-> (done && done_op == OP_ADD))
        else note_failure("add engine went idle without its done pulse");

    // on a tie the add report comes first
    assert property (@(posedge clk) disable iff (rst)
        $fell(busy[OP_CONJ_T]) |-> (done && (done_op == OP_CONJ_T || $fell(busy[OP_ADD]))))
        else note_failure("conjugate-transpose engine went idle without a done pulse");

    // busy is gone by the cycle after the done pulse
    assert property (@(posedge clk) disable iff (rst)
        (done && done_op == OP_ADD) |=> !busy[OP_ADD])
        else note_failure("add engine still busy after its done pulse");

    assert property (@(posedge clk) disable iff (rst)
        (done && done_op == OP_CONJ_T) |=> !busy[OP_CONJ_T])
        else note_failure("conjugate-transpose engine still busy after its done pulse");

    assert property (@(posedge clk) disable iff (rst)
        (done && done_op == OP_ADD) |-> $past(busy[OP_ADD]))
        else note_failure("add done pulse while the add engine was idle");

    assert property (@(posedge clk) disable iff (rst)
        (done && done_op == OP_CONJ_T) |->
            ($past(busy[OP_CONJ_T]) || $past(busy[OP_CONJ_T], 2)))
        else note_failure("conjugate-transpose done pulse while that engine was idle");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, checks %0d, errors %0d",
            WATCHDOG_CYCLES, checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        cplx_t e;
        seed     = 45;
        errors   = 0;
        checks   = 0;
        started  = 1'b0;
        rst      = 1'b1;
        cmd_stb  = 1'b0;
        cmd      = '0;
        host_stb = 1'b0;
        host_req = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) next_cycle();
        started = 1'b1;

        rand_elem(e);
        host_write(60, e);
        host_read_check(60);

        load_add_operands(0, 4);
        predict_add(0, 4, 8);
        issue_cmd(OP_ADD, 0, 4, 8);
        wait_done(OP_ADD, 1);
        check_done_count(1, 0);
        check_region(8);

        load_random(16);
        predict_conj(16, 20);
        issue_cmd(OP_CONJ_T, 16, 0, 20);
        wait_done(OP_CONJ_T, 1);
        check_done_count(1, 1);
        check_region(20);

        // both engines one cycle apart while the host keeps reading
        load_add_operands(24, 28);
        load_random(36);
        predict_add(24, 28, 32);
        predict_conj(36, 40);
        fork
            begin
                issue_cmd(OP_ADD, 24, 28, 32);
                issue_cmd(OP_CONJ_T, 36, 0, 40);
            end
            begin
                for (int k = 0; k < 12; k++) begin
                    host_read_check(k);
                    next_cycle();
                end
            end
        join
        wait_done(OP_ADD, 2);
        wait_done(OP_CONJ_T, 2);
        check_done_count(2, 2);
        check_region(32);
        check_region(40);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/cmat_pkg.sv
src/fp64_add.sv
src/mem_arbiter.sv
src/cmat_mem.sv
src/cmat_add_engine.sv
src/cmat_conj_transpose.sv
src/cmat_unit.sv
testbench/tb_cmat_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message in the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cmat_unit \
    -f filelist.f --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
exit 1
